// ==== project.f ====
+incdir+tests
rtl/sifhPkg.sv
rtl/sampleDecode.sv
rtl/binAccumulate.sv
rtl/peakTracker.sv
rtl/histogramTop.sv
tests/histogramTb.sv

// ==== rtl/binAccumulate.sv ====
module binAccumulate (
    input  logic                  clk,
    input  logic                  combin_res,
    input  sifhPkg::binEvent_t    binEvent,
    output sifhPkg::countUpdate_t update
);

    // one histogram per pixel
    logic [sifhPkg::countWidth-1:0] countMem [sifhPkg::pixelCount][sifhPkg::binsPerHist];
    logic [sifhPkg::pixelCount-1:0][sifhPkg::binsPerHist-1:0] binValid;
    logic [sifhPkg::countWidth-1:0] storedCount;
    logic [sifhPkg::countWidth-1:0] nextCount;

    always_comb begin
        // a bin without its valid bit reads as empty
        if (binValid[binEvent.pixel][binEvent.bin]) begin
            storedCount = countMem[binEvent.pixel][binEvent.bin];
        end else begin
            storedCount = '0;
        end

        if (&storedCount) begin
            nextCount = storedCount;       // saturate
        end else begin
            nextCount = storedCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (binEvent.valid) begin
            countMem[binEvent.pixel][binEvent.bin] <= nextCount;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (binEvent.lastOfPass) begin
            binValid <= '0;                // whole memory empty for the next pass
        end else if (binEvent.valid) begin
            binValid[binEvent.pixel][binEvent.bin] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            update <= '0;
        end else begin
            update.valid      <= binEvent.valid;
            update.fine       <= binEvent.fine;
            update.pixel      <= binEvent.pixel;
            update.bin        <= binEvent.bin;
            update.count      <= binEvent.valid ? nextCount : '0;
            update.lastOfPass <= binEvent.lastOfPass;
        end
    end

endmodule

// ==== rtl/histogramTop.sv ====
module histogramTop (
    input  logic                           clk,
    input  logic                           combin_res,
    input  logic                           sampleValid,
    input  sifhPkg::sampleWord_t           sample,
    output logic                           fineMode,
    output logic                           peakValid,
    output logic [sifhPkg::pixelWidth-1:0] peakPixel,
    output sifhPkg::sampleWord_t           peakTime
);

    sifhPkg::windowArray_t windows;
    sifhPkg::binEvent_t    binEvent;
    sifhPkg::countUpdate_t update;

    sampleDecode decodeStage (
        .clk        (clk),
        .combin_res (combin_res),
        .sampleValid(sampleValid),
        .sample     (sample),
        .windows    (windows),
        .binEvent   (binEvent),
        .fineMode   (fineMode)
    );

    binAccumulate executeStage (
        .clk        (clk),
        .combin_res (combin_res),
        .binEvent   (binEvent),
        .update     (update)
    );

    peakTracker resultStage (
        .clk        (clk),
        .combin_res (combin_res),
        .update     (update),
        .windows    (windows),     // fed back to decode
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakTime   (peakTime)
    );

endmodule

// ==== rtl/peakTracker.sv ====
module peakTracker (
    input  logic                           clk,
    input  logic                           combin_res,
    input  sifhPkg::countUpdate_t          update,
    output sifhPkg::windowArray_t          windows,
    output logic                           peakValid,
    output logic [sifhPkg::pixelWidth-1:0] peakPixel,
    output sifhPkg::sampleWord_t           peakTime
);

    logic [sifhPkg::countWidth-1:0] maxCount [sifhPkg::pixelCount];
    logic [sifhPkg::binWidth-1:0]   peakBin  [sifhPkg::pixelCount];
    logic                           passDone;    // one cycle after the last update
    logic                           passFine;    // mode of the pass that just ended
    logic [sifhPkg::pixelCount-1:0][sifhPkg::sampleWidth-1:0] pendingTime;
    logic [sifhPkg::pixelWidth-1:0] nextPixel;

    // clamped low edge of the fine window around a coarse peak
    function automatic logic [sifhPkg::sampleWidth-1:0] placeWindow(
        input logic [sifhPkg::binWidth-1:0] coarsePeak
    );
        logic [sifhPkg::sampleWidth-1:0] centre;
        centre = {coarsePeak, {(sifhPkg::sampleWidth - sifhPkg::binWidth){1'b0}}};
        if (centre <= sifhPkg::halfWindow) begin
            return '0;
        end else if (centre >= sifhPkg::sampleTop - sifhPkg::halfWindow) begin
            return sifhPkg::sampleTop - (sifhPkg::halfWindow << 1) + 1'b1;
        end
        return centre - sifhPkg::halfWindow;
    endfunction

    function automatic logic [sifhPkg::sampleWidth-1:0] fineTime(
        input logic [sifhPkg::sampleWidth-1:0] low,
        input logic [sifhPkg::binWidth-1:0]    bin
    );
        return low + {{(sifhPkg::sampleWidth - sifhPkg::binWidth){1'b0}}, bin};
    endfunction

    assign nextPixel = peakPixel + 1'b1;

    always_ff @(posedge clk) begin
        if (passDone && passFine) begin
            for (int i = 0; i < sifhPkg::pixelCount; i++) begin
                pendingTime[i] <= fineTime(windows[i], peakBin[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < sifhPkg::pixelCount; i++) begin
                maxCount[i] <= '0;
                peakBin[i]  <= '0;
            end
            passDone  <= 1'b0;
            passFine  <= 1'b0;
            windows   <= '0;
            peakValid <= 1'b0;
            peakPixel <= '0;
            peakTime  <= '0;
        end else begin
            passDone <= update.lastOfPass;
            if (update.lastOfPass) begin
                passFine <= update.fine;
            end

            if (passDone) begin
                for (int i = 0; i < sifhPkg::pixelCount; i++) begin
                    maxCount[i] <= '0;             // fresh maxima for the next pass
                    peakBin[i]  <= '0;
                    if (!passFine) begin
                        windows[i] <= placeWindow(peakBin[i]);
                    end
                end
            end else if (update.valid && (update.count > maxCount[update.pixel])) begin
                maxCount[update.pixel] <= update.count;   // ties keep earlier bin
                peakBin[update.pixel]  <= update.bin;
            end

            // walk the pixels after a fine pass
            if (passDone && passFine) begin
                peakValid     <= 1'b1;
                peakPixel     <= '0;
                peakTime.raw  <= fineTime(windows[0], peakBin[0]);
            end else if (peakValid) begin
                if (peakPixel == sifhPkg::pixelWidth'(sifhPkg::pixelCount - 1)) begin
                    peakValid <= 1'b0;
                end else begin
                    peakPixel    <= nextPixel;
                    peakTime.raw <= pendingTime[nextPixel];
                end
            end
        end
    end

endmodule

// ==== rtl/sampleDecode.sv ====
module sampleDecode (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  sampleValid,
    input  sifhPkg::sampleWord_t  sample,
    input  sifhPkg::windowArray_t windows,
    output sifhPkg::binEvent_t    binEvent,
    output logic                  fineMode
);

    logic [sifhPkg::sampleCntWidth-1:0] sampleCnt;
    logic [sifhPkg::pixelWidth-1:0]     pixelCnt;
    logic [sifhPkg::acqCntWidth-1:0]    acqCnt;
    logic                               passMode;     // mode of samples arriving now
    logic [1:0]                         modeDelay;    // lines fineMode up with the windows
    logic                               lastSample;
    logic [sifhPkg::sampleWidth-1:0]    low;
    logic [sifhPkg::sampleWidth-1:0]    offset;
    logic                               inWindow;
    sifhPkg::binEvent_t                 nextEvent;

    assign lastSample = (sampleCnt == sifhPkg::sampleCntWidth'(sifhPkg::samplesPerPixel - 1))
                     && (pixelCnt == sifhPkg::pixelWidth'(sifhPkg::pixelCount - 1))
                     && (acqCnt == sifhPkg::acqCntWidth'(sifhPkg::acqCount - 1));

    always_comb begin
        low      = windows[pixelCnt];
        offset   = sample.raw - low;
        inWindow = (sample.raw >= low) && (offset[sifhPkg::sampleWidth-1:sifhPkg::binWidth] == '0);

        nextEvent.valid      = sampleValid && (!passMode || inWindow); // outliers dropped
        nextEvent.fine       = passMode;
        nextEvent.pixel      = pixelCnt;
        nextEvent.bin        = passMode ? offset[sifhPkg::binWidth-1:0] : sample.coarse.coarseBin;
        nextEvent.lastOfPass = sampleValid && lastSample;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
            passMode  <= 1'b0;
            modeDelay <= '0;
            fineMode  <= 1'b0;
            binEvent  <= '0;
        end else begin
            binEvent  <= nextEvent;
            modeDelay <= {modeDelay[0], passMode};
            fineMode  <= modeDelay[1];
            if (sampleValid) begin
                if (sampleCnt == sifhPkg::sampleCntWidth'(sifhPkg::samplesPerPixel - 1)) begin
                    sampleCnt <= '0;
                    if (pixelCnt == sifhPkg::pixelWidth'(sifhPkg::pixelCount - 1)) begin
                        pixelCnt <= '0;
                        if (acqCnt == sifhPkg::acqCntWidth'(sifhPkg::acqCount - 1)) begin
                            acqCnt   <= '0;
                            passMode <= ~passMode;   // coarse and fine alternate
                        end else begin
                            acqCnt <= acqCnt + 1'b1;
                        end
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/sifhPkg.sv ====
package sifhPkg;

    localparam int sampleWidth     = 12;              // bits per time sample
    localparam int binWidth        = 6;               // bits of a bin index
    localparam int binsPerHist     = 1 << binWidth;
    localparam int pixelCount      = 4;
    localparam int pixelWidth      = 2;
    localparam int samplesPerPixel = 8;               // per pixel per acquisition
    localparam int acqCount        = 2;               // acquisitions per pass
    localparam int countWidth      = 8;               // saturating bin count

    localparam int sampleCntWidth  = $clog2(samplesPerPixel);
    localparam int acqCntWidth     = $clog2(acqCount);

    // half the fine window width
    localparam logic [sampleWidth-1:0] halfWindow = 32;
    localparam logic [sampleWidth-1:0] sampleTop  = '1;   // top of sample range

    // one sample word read whole in the fine pass or split in the coarse pass
    typedef union packed {
        logic [sampleWidth-1:0] raw;
        struct packed {
            logic [binWidth-1:0]             coarseBin;
            logic [sampleWidth-binWidth-1:0] fraction;
        } coarse;
    } sampleWord_t;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        logic                  fine;        // pass mode of this sample
        logic [pixelWidth-1:0] pixel;
        logic [binWidth-1:0]   bin;
        logic                  lastOfPass;
    } binEvent_t;

    // execute to result
    typedef struct packed {
        logic                  valid;
        logic                  fine;
        logic [pixelWidth-1:0] pixel;
        logic [binWidth-1:0]   bin;
        logic [countWidth-1:0] count;      // count after this sample
        logic                  lastOfPass;
    } countUpdate_t;

    // low edge of each pixel's fine window
    typedef logic [pixelCount-1:0][sampleWidth-1:0] windowArray_t;

endpackage

// ==== tests/histogramModel.svh ====
`ifndef HISTOGRAM_MODEL_SVH
`define HISTOGRAM_MODEL_SVH

localparam int passLength = sifhPkg::pixelCount * sifhPkg::samplesPerPixel * sifhPkg::acqCount;
localparam int countMax   = (1 << sifhPkg::countWidth) - 1;

int passSample [passLength];   // one pass in strobe order

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// clamped low edge around a coarse peak bin
function automatic int windowLow(input int coarsePeak);
    int centre;
    int halfWin;
    int top;
    centre  = coarsePeak << (sifhPkg::sampleWidth - sifhPkg::binWidth);
    halfWin = int'(sifhPkg::halfWindow);
    top     = (1 << sifhPkg::sampleWidth) - 1;
    if (centre <= halfWin) begin
        return 0;
    end else if (centre >= top - halfWin) begin
        return top - 2 * halfWin + 1;
    end
    return centre - halfWin;
endfunction

// histogram of one pixel where the first bin to exceed the maximum wins
function automatic int replayPeak(input int pixel, input bit fine, input int low);
    int counts [sifhPkg::binsPerHist];
    int maxCount;
    int peak;
    int bin;
    int idx;
    for (bin = 0; bin < sifhPkg::binsPerHist; bin++) begin
        counts[bin] = 0;
    end
    maxCount = 0;
    peak     = 0;
    for (idx = 0; idx < passLength; idx++) begin
        if ((idx / sifhPkg::samplesPerPixel) % sifhPkg::pixelCount == pixel) begin
            bin = -1;
            if (!fine) begin
                bin = passSample[idx] >> (sifhPkg::sampleWidth - sifhPkg::binWidth);
            end else if (passSample[idx] >= low
                         && passSample[idx] - low < sifhPkg::binsPerHist) begin
                bin = passSample[idx] - low;     // outliers never get a bin
            end
            if (bin >= 0) begin
                if (counts[bin] < countMax) begin
                    counts[bin] = counts[bin] + 1;
                end
                if (counts[bin] > maxCount) begin
                    maxCount = counts[bin];
                    peak     = bin;
                end
            end
        end
    end
    return peak;
endfunction

`endif

// ==== tests/histogramTb.sv ====
module histogramTb;

    `include "histogramModel.svh"

    localparam int resetCycles   = 10;
    localparam int roundCount    = 3;
    localparam int gapCycles     = 6;
    localparam int timeoutCycles = resetCycles + roundCount * 2 * (passLength + gapCycles) + 170;

    logic                           clk;
    logic                           combin_res;
    logic                           sampleValid;
    sifhPkg::sampleWord_t           sample;
    logic                           fineMode;
    logic                           peakValid;
    logic [sifhPkg::pixelWidth-1:0] peakPixel;
    sifhPkg::sampleWord_t           peakTime;

    logic [31:0] rngState = 32'h378ba0f7;
    int          cycleCount = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    int          pulseCount = 0;
    int          target  [sifhPkg::pixelCount];
    int          low     [sifhPkg::pixelCount];
    int          expTime [sifhPkg::pixelCount];

    // monitor state tracked from the sample strobes
    int          seenSamples = 0;
    bit          seenFine = 1'b0;
    int          lastCoarseCycle = -100;
    int          lastFineCycle = -100;
    bit          expFine = 1'b0;
    bit          expPeak;

    histogramTop uut (
        .clk        (clk),
        .combin_res (combin_res),
        .sampleValid(sampleValid),
        .sample     (sample),
        .fineMode   (fineMode),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakTime   (peakTime)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic pickTargets(input int round);
        int p;
        for (p = 0; p < sifhPkg::pixelCount; p++) begin
            rngState  = xorshift32(rngState);
            target[p] = rngState[5:0] * 64 + 8 + (rngState[15:8] % 17);
        end
        if (round == 0) begin
            target[0] = 10;            // bottom clamp
            target[1] = 4048;          // top coarse bin
        end
    endtask

    task automatic fillPass(input bit fine);
        int idx;
        int p;
        for (idx = 0; idx < passLength; idx++) begin
            p = (idx / sifhPkg::samplesPerPixel) % sifhPkg::pixelCount;
            rngState = xorshift32(rngState);
            passSample[idx] = target[p] + int'(rngState[2:0]) - 4;
            if (fine && rngState[7:5] == 3'd0) begin
                passSample[idx] = target[p] ^ 12'h800;   // far outlier
            end
        end
    endtask

    task automatic drivePass();
        int idx;
        for (idx = 0; idx < passLength; idx++) begin
            @(posedge clk);
            sampleValid <= 1'b1;
            sample.raw  <= passSample[idx][sifhPkg::sampleWidth-1:0];
        end
        @(posedge clk);
        sampleValid <= 1'b0;
        repeat (gapCycles - 1) @(posedge clk);
    endtask

    // outputs checked at the falling edge away from stimulus updates
    always @(negedge clk) begin
        if (combin_res && sampleValid) begin
            seenSamples = seenSamples + 1;
            if (seenSamples == passLength) begin
                seenSamples = 0;
                if (seenFine) begin
                    lastFineCycle = cycleCount;
                end else begin
                    lastCoarseCycle = cycleCount;
                end
                seenFine = !seenFine;
            end
        end
        if (cycleCount == lastCoarseCycle + 4) expFine = 1'b1;
        if (cycleCount == lastFineCycle + 4) expFine = 1'b0;
        expPeak = (cycleCount >= lastFineCycle + 4) && (cycleCount <= lastFineCycle + 7);
        checkValue("fineMode", expFine, fineMode);
        checkValue("peakValid", expPeak, peakValid);
        if (peakValid) begin
            pulseCount = pulseCount + 1;
        end
        if (peakValid && expPeak) begin
            checkValue("peakPixel", cycleCount - lastFineCycle - 4, peakPixel);
            checkValue($sformatf("peakTime pixel %0d", peakPixel), expTime[peakPixel],
                       peakTime.raw);
        end
    end

    initial begin
        int round;
        int p;
        combin_res  = 1'b0;
        sampleValid = 1'b0;
        sample.raw  = '0;
        repeat (resetCycles) @(posedge clk);
        combin_res <= 1'b1;

        for (round = 0; round < roundCount; round++) begin
            pickTargets(round);
            fillPass(1'b0);
            for (p = 0; p < sifhPkg::pixelCount; p++) begin
                low[p] = windowLow(replayPeak(p, 1'b0, 0));
            end
            drivePass();
            fillPass(1'b1);
            for (p = 0; p < sifhPkg::pixelCount; p++) begin
                expTime[p] = low[p] + replayPeak(p, 1'b1, low[p]);
            end
            drivePass();
        end

        while (pulseCount < roundCount * sifhPkg::pixelCount) @(posedge clk);
        repeat (4) @(posedge clk);     // room for a stray extra pulse
        checkValue("pulseCount", roundCount * sifhPkg::pixelCount, pulseCount);

        $display("checks: %0d  errors: %0d  peak pulses: %0d", checkCount, errorCount,
                 pulseCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
